// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_banked_cache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_LINE := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_LINE)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/bank_router.sv ====
module bank_router #(
    parameter int NUM_BANKS = 2
) (
    input  logic                                 clk,
    input  logic                                 arst_n_i,

    // CPU side
    input  logic                                 mem_read_i,
    input  logic                                 mem_write_i,
    input  lc3b_pkg::lc3b_word                   mem_address_i,
    output logic                                 mem_resp_o,
    output lc3b_pkg::lc3b_word                   mem_rdata_o,

    // Bank side
    output logic [NUM_BANKS-1:0]                 bank_read_o,
    output logic [NUM_BANKS-1:0]                 bank_write_o,
    input  logic [NUM_BANKS-1:0]                 bank_resp_i,
    input  lc3b_pkg::lc3b_word [NUM_BANKS-1:0]   bank_rdata_i
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);

    logic [BANK_BITS-1:0] bank_sel;
    logic [BANK_BITS-1:0] bank_sel_q;     // Bank of the accepted request
    logic [NUM_BANKS-1:0] bank_dec;
    logic                 busy_q;

    // Bank field sits right above the byte offset
    assign bank_sel = mem_address_i[lc3b_pkg::OFFSET_BITS +: BANK_BITS];

    always_comb begin
        bank_dec           = '0;
        bank_dec[bank_sel] = 1'b1;
    end

    assign bank_read_o  = bank_dec & {NUM_BANKS{mem_read_i}};
    assign bank_write_o = bank_dec & {NUM_BANKS{mem_write_i}};

    // Accept on the first strobe, release on the response pulse
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            bank_sel_q <= '0;
        end else if (!busy_q && (mem_read_i || mem_write_i)) begin
            busy_q     <= 1'b1;
            bank_sel_q <= bank_sel;
        end else if (mem_resp_o) begin
            busy_q     <= 1'b0;
        end
    end

    assign mem_resp_o  = busy_q & bank_resp_i[bank_sel_q];
    assign mem_rdata_o = bank_rdata_i[bank_sel_q];   // Valid while resp is high

endmodule : bank_router

// ==== hw/banked_cache.sv ====
module banked_cache #(
    parameter int NUM_BANKS     = 2,
    parameter int SETS_PER_BANK = 4
) (
    input  logic                       clk,
    input  logic                       arst_n_i,

    // CPU memory port
    input  logic                       mem_read_i,
    input  logic                       mem_write_i,
    input  lc3b_pkg::lc3b_mem_wmask    mem_byte_enable_i,
    input  lc3b_pkg::lc3b_word         mem_address_i,
    input  lc3b_pkg::lc3b_word         mem_wdata_i,
    output logic                       mem_resp_o,
    output lc3b_pkg::lc3b_word         mem_rdata_o,

    // Physical memory port
    output logic                       pmem_read_o,
    output logic                       pmem_write_o,
    output lc3b_pkg::lc3b_word         pmem_address_o,
    output lc3b_pkg::lc3b_cacheline    pmem_wdata_o,
    input  logic                       pmem_resp_i,
    input  lc3b_pkg::lc3b_cacheline    pmem_rdata_i
);

    // ==============================
    // Router to banks
    // ==============================
    logic [NUM_BANKS-1:0]               bank_read;
    logic [NUM_BANKS-1:0]               bank_write;
    logic [NUM_BANKS-1:0]               bank_resp;
    lc3b_pkg::lc3b_word [NUM_BANKS-1:0] bank_rdata;

    // Banks to arbiter
    logic [NUM_BANKS-1:0]                    miss_read;
    logic [NUM_BANKS-1:0]                    miss_write;
    lc3b_pkg::lc3b_word [NUM_BANKS-1:0]      miss_address;
    lc3b_pkg::lc3b_cacheline [NUM_BANKS-1:0] miss_wdata;
    logic [NUM_BANKS-1:0]                    miss_resp;
    lc3b_pkg::lc3b_cacheline [NUM_BANKS-1:0] miss_rdata;

    bank_router #(
        .NUM_BANKS(NUM_BANKS)
    ) u_router (
        .clk,
        .arst_n_i,
        .mem_read_i,
        .mem_write_i,
        .mem_address_i,
        .mem_resp_o,
        .mem_rdata_o,
        .bank_read_o  (bank_read),
        .bank_write_o (bank_write),
        .bank_resp_i  (bank_resp),
        .bank_rdata_i (bank_rdata)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
        l1_bank #(
            .NUM_BANKS     (NUM_BANKS),
            .SETS_PER_BANK (SETS_PER_BANK),
            .BANK_ID       (i)
        ) u_bank (
            .clk,
            .arst_n_i,
            .read_i         (bank_read[i]),
            .write_i        (bank_write[i]),
            .byte_enable_i  (mem_byte_enable_i),   // Shared by all banks
            .address_i      (mem_address_i),
            .wdata_i        (mem_wdata_i),
            .resp_o         (bank_resp[i]),
            .rdata_o        (bank_rdata[i]),
            .pmem_read_o    (miss_read[i]),
            .pmem_write_o   (miss_write[i]),
            .pmem_address_o (miss_address[i]),
            .pmem_wdata_o   (miss_wdata[i]),
            .pmem_resp_i    (miss_resp[i]),
            .pmem_rdata_i   (miss_rdata[i])
        );
    end

    pmem_arbiter #(
        .NUM_BANKS(NUM_BANKS)
    ) u_arbiter (
        .clk,
        .arst_n_i,
        .req_read_i    (miss_read),
        .req_write_i   (miss_write),
        .req_address_i (miss_address),
        .req_wdata_i   (miss_wdata),
        .req_resp_o    (miss_resp),
        .req_rdata_o   (miss_rdata),
        .pmem_read_o,
        .pmem_write_o,
        .pmem_address_o,
        .pmem_wdata_o,
        .pmem_resp_i,
        .pmem_rdata_i
    );

endmodule : banked_cache

// ==== hw/l1_bank.sv ====
module l1_bank #(
    parameter int NUM_BANKS     = 2,
    parameter int SETS_PER_BANK = 4,
    parameter int BANK_ID       = 0
) (
    input  logic                       clk,
    input  logic                       arst_n_i,

    // CPU side, steered by the router
    input  logic                       read_i,
    input  logic                       write_i,
    input  lc3b_pkg::lc3b_mem_wmask    byte_enable_i,
    input  lc3b_pkg::lc3b_word         address_i,
    input  lc3b_pkg::lc3b_word         wdata_i,
    output logic                       resp_o,
    output lc3b_pkg::lc3b_word         rdata_o,

    // Miss port towards the arbiter
    output logic                       pmem_read_o,
    output logic                       pmem_write_o,
    output lc3b_pkg::lc3b_word         pmem_address_o,
    output lc3b_pkg::lc3b_cacheline    pmem_wdata_o,
    input  logic                       pmem_resp_i,
    input  lc3b_pkg::lc3b_cacheline    pmem_rdata_i
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int SET_BITS  = $clog2(SETS_PER_BANK);
    localparam int SET_LSB   = lc3b_pkg::OFFSET_BITS + BANK_BITS;
    localparam int TAG_BITS  = lc3b_pkg::ADDR_BITS - SET_LSB - SET_BITS;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RESPOND,
        ST_WRITEBACK,
        ST_FILL
    } state_t;

    state_t state_q;
    state_t state_d;

    // ==============================
    // Arrays
    // ==============================
    lc3b_pkg::lc3b_cacheline  data_q [SETS_PER_BANK];
    logic [TAG_BITS-1:0]      tag_q  [SETS_PER_BANK];
    logic [SETS_PER_BANK-1:0] valid_q;
    logic [SETS_PER_BANK-1:0] dirty_q;

    logic [SET_BITS-1:0]                set_idx;
    logic [TAG_BITS-1:0]                tag_in;
    logic [lc3b_pkg::WORD_SEL_BITS-1:0] word_sel;
    lc3b_pkg::lc3b_cacheline            cur_line;
    lc3b_pkg::lc3b_cacheline            merged_line;
    logic                               req;
    logic                               hit;
    logic                               store_hit;
    logic                               fill_done;

    assign set_idx  = address_i[SET_LSB +: SET_BITS];
    assign tag_in   = address_i[lc3b_pkg::ADDR_BITS-1 -: TAG_BITS];
    assign word_sel = address_i[1 +: lc3b_pkg::WORD_SEL_BITS];   // Bit 0 picks the byte
    assign cur_line = data_q[set_idx];

    assign req       = read_i | write_i;
    assign hit       = valid_q[set_idx] && (tag_q[set_idx] == tag_in);
    assign store_hit = (state_q == ST_IDLE) && write_i && hit;
    assign fill_done = (state_q == ST_FILL) && pmem_resp_i;

    // Byte merge of a store into the resident line
    always_comb begin
        merged_line = cur_line;
        if (byte_enable_i[0]) begin
            merged_line[16*word_sel +: 8] = wdata_i[7:0];
        end
        if (byte_enable_i[1]) begin
            merged_line[16*word_sel + 8 +: 8] = wdata_i[15:8];
        end
    end

    // ==============================
    // Miss FSM
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req) begin
                    if (hit) begin
                        state_d = ST_RESPOND;
                    end else if (valid_q[set_idx] && dirty_q[set_idx]) begin
                        state_d = ST_WRITEBACK;   // Old line goes out first
                    end else begin
                        state_d = ST_FILL;
                    end
                end
            end
            ST_RESPOND:   state_d = ST_IDLE;
            ST_WRITEBACK: if (pmem_resp_i) state_d = ST_FILL;
            ST_FILL:      if (pmem_resp_i) state_d = ST_IDLE;   // Retried as a hit
            default:      state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_done) begin
                valid_q[set_idx] <= 1'b1;
                dirty_q[set_idx] <= 1'b0;
            end else if (store_hit) begin
                dirty_q[set_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_q[set_idx] <= pmem_rdata_i;
            tag_q[set_idx]  <= tag_in;
        end else if (store_hit) begin
            data_q[set_idx] <= merged_line;
        end
    end

    // ==============================
    // Outputs
    // ==============================
    assign resp_o  = (state_q == ST_RESPOND);
    assign rdata_o = cur_line[16*word_sel +: 16];

    assign pmem_read_o  = (state_q == ST_FILL);
    assign pmem_write_o = (state_q == ST_WRITEBACK);
    assign pmem_wdata_o = cur_line;

    // Victim address rebuilt from stored tag, set and own bank number
    always_comb begin
        if (state_q == ST_WRITEBACK) begin
            pmem_address_o = {tag_q[set_idx], set_idx, BANK_BITS'(BANK_ID),
                              {lc3b_pkg::OFFSET_BITS{1'b0}}};
        end else begin
            pmem_address_o = {address_i[lc3b_pkg::ADDR_BITS-1:lc3b_pkg::OFFSET_BITS],
                              {lc3b_pkg::OFFSET_BITS{1'b0}}};
        end
    end

endmodule : l1_bank

// ==== hw/lc3b_pkg.sv ====
package lc3b_pkg;

    // ==============================
    // Address layout
    // ==============================
    parameter int ADDR_BITS     = 16;
    parameter int OFFSET_BITS   = 4;    // Byte offset inside a line
    parameter int WORD_SEL_BITS = 3;    // Word index inside a line

    // ==============================
    // Data types
    // ==============================

    // Data word, also used for byte addresses
    typedef logic [15:0] lc3b_word;

    // Eight words per line
    typedef logic [127:0] lc3b_cacheline;

    // Bit 0 low byte, bit 1 high byte
    typedef logic [1:0] lc3b_mem_wmask;

endpackage : lc3b_pkg

// ==== hw/pmem_arbiter.sv ====
module pmem_arbiter #(
    parameter int NUM_BANKS = 2
) (
    input  logic                                    clk,
    input  logic                                    arst_n_i,

    // Bank miss ports
    input  logic [NUM_BANKS-1:0]                    req_read_i,
    input  logic [NUM_BANKS-1:0]                    req_write_i,
    input  lc3b_pkg::lc3b_word [NUM_BANKS-1:0]      req_address_i,
    input  lc3b_pkg::lc3b_cacheline [NUM_BANKS-1:0] req_wdata_i,
    output logic [NUM_BANKS-1:0]                    req_resp_o,
    output lc3b_pkg::lc3b_cacheline [NUM_BANKS-1:0] req_rdata_o,

    // Physical memory
    output logic                                    pmem_read_o,
    output logic                                    pmem_write_o,
    output lc3b_pkg::lc3b_word                      pmem_address_o,
    output lc3b_pkg::lc3b_cacheline                 pmem_wdata_o,
    input  logic                                    pmem_resp_i,
    input  lc3b_pkg::lc3b_cacheline                 pmem_rdata_i
);

    logic [NUM_BANKS-1:0] req_any;
    logic [NUM_BANKS-1:0] first_req;   // Lowest index wins
    logic [NUM_BANKS-1:0] grant_q;     // Locked grant, zero when idle
    logic [NUM_BANKS-1:0] grant_oh;

    assign req_any   = req_read_i | req_write_i;
    assign first_req = req_any & (~req_any + NUM_BANKS'(1));
    assign grant_oh  = (|grant_q) ? grant_q : first_req;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant_q <= '0;
        end else if (pmem_resp_i) begin
            grant_q <= '0;   // Transfer done
        end else begin
            grant_q <= grant_oh;
        end
    end

    // ==============================
    // Routing
    // ==============================
    always_comb begin
        pmem_read_o    = 1'b0;
        pmem_write_o   = 1'b0;
        pmem_address_o = '0;
        pmem_wdata_o   = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            req_rdata_o[i] = grant_oh[i] ? pmem_rdata_i : '0;
            if (grant_oh[i]) begin
                pmem_read_o    = req_read_i[i];
                pmem_write_o   = req_write_i[i];
                pmem_address_o = req_address_i[i];
                pmem_wdata_o   = req_wdata_i[i];
            end
        end
    end

    assign req_resp_o = grant_oh & {NUM_BANKS{pmem_resp_i}};

endmodule : pmem_arbiter

// ==== project.f ====
hw/lc3b_pkg.sv
hw/bank_router.sv
hw/l1_bank.sv
hw/pmem_arbiter.sv
hw/banked_cache.sv
sim/banked_cache_assertions.sv
sim/tb_pmem.sv
sim/cache_checker.sv
sim/tb_banked_cache.sv

// ==== sim/banked_cache_assertions.sv ====
module banked_cache_assertions #(
    parameter int NUM_BANKS = 2
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  mem_resp_i,
    input  logic                  pmem_read_i,
    input  logic                  pmem_write_i,
    input  lc3b_pkg::lc3b_word    pmem_address_i,
    input  logic                  pmem_resp_i,
    input  logic [NUM_BANKS-1:0]  grant_i,
    input  logic [NUM_BANKS-1:0]  req_i
);

    a_strobe_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(pmem_read_i && pmem_write_i))
        else $error("pmem read and write strobes high in the same cycle");

    // Address held while the memory has not answered
    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((pmem_read_i || pmem_write_i) && !pmem_resp_i) |=> $stable(pmem_address_i))
        else $error("pmem address changed while waiting for resp");

    a_resp_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_resp_i |=> !mem_resp_i)
        else $error("mem_resp_o high for more than one cycle");

    // Locked grant must still belong to a requesting bank
    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(grant_i) && ((grant_i & ~req_i) == '0))
        else $error("arbiter grant not one-hot or given to an idle bank");

endmodule : banked_cache_assertions

bind banked_cache banked_cache_assertions #(
    .NUM_BANKS(NUM_BANKS)
) u_assertions (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .mem_resp_i     (mem_resp_o),
    .pmem_read_i    (pmem_read_o),
    .pmem_write_i   (pmem_write_o),
    .pmem_address_i (pmem_address_o),
    .pmem_resp_i    (pmem_resp_i),
    .grant_i        (u_arbiter.grant_oh),
    .req_i          (u_arbiter.req_any)
);

// ==== sim/cache_checker.sv ====
module cache_checker #(
    parameter int NUM_BANKS     = 2,
    parameter int SETS_PER_BANK = 4
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     mem_read_i,
    input  logic                     mem_write_i,
    input  lc3b_pkg::lc3b_mem_wmask  mem_byte_enable_i,
    input  lc3b_pkg::lc3b_word       mem_address_i,
    input  lc3b_pkg::lc3b_word       mem_wdata_i,
    input  logic                     mem_resp_i,
    input  lc3b_pkg::lc3b_word       mem_rdata_i,
    input  logic                     pmem_read_i,
    input  logic                     pmem_write_i,
    input  lc3b_pkg::lc3b_word       pmem_address_i,
    input  lc3b_pkg::lc3b_cacheline  pmem_wdata_i,
    input  logic                     pmem_resp_i,
    output int                       errors_o,
    output int                       checks_o
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int SET_BITS  = $clog2(SETS_PER_BANK);
    localparam int IDX_BITS  = BANK_BITS + SET_BITS;   // Set and bank fields together
    localparam int TAG_LSB   = lc3b_pkg::OFFSET_BITS + IDX_BITS;
    localparam int NUM_SETS  = NUM_BANKS * SETS_PER_BANK;

    // ==============================
    // Shadow memory and cache model
    // ==============================
    logic [15:0] shadow [32768];
    bit          m_valid [NUM_SETS];
    bit          m_dirty [NUM_SETS];
    int          m_tag   [NUM_SETS];

    logic [16:0] exp_ops [$];   // {is_write, line address}
    bit          in_flight;
    bit          req_hit;
    bit          req_write;
    logic [15:0] req_addr;
    logic [15:0] exp_word;
    int          cycle = 0;
    int          accept_cycle = 0;
    int          errors = 0;
    int          checks = 0;

    assign errors_o = errors;
    assign checks_o = checks;

    function automatic logic [15:0] pattern_word(input logic [14:0] widx);
        return {widx[6:0], widx[14:7], 1'b1} ^ 16'h3c5a;
    endfunction

    // Expected word after the access, plus the pmem traffic it needs
    function automatic logic [15:0] access_ref(
        input  logic [15:0] addr,
        input  bit          is_write,
        input  logic [1:0]  be,
        input  logic [15:0] wdata,
        output bit          hit,
        output bit          wb,
        output logic [15:0] wb_addr
    );
        int          idx;
        logic [15:0] word;
        idx     = int'(addr[lc3b_pkg::OFFSET_BITS +: IDX_BITS]);
        hit     = m_valid[idx] && (m_tag[idx] == int'(addr >> TAG_LSB));
        wb      = !hit && m_valid[idx] && m_dirty[idx];
        wb_addr = 16'((m_tag[idx] << TAG_LSB) | (idx << lc3b_pkg::OFFSET_BITS));
        word    = shadow[addr[15:1]];
        if (is_write && be[0]) word[7:0] = wdata[7:0];
        if (is_write && be[1]) word[15:8] = wdata[15:8];
        return word;
    endfunction

    function automatic lc3b_pkg::lc3b_cacheline shadow_line(input logic [15:0] line_addr);
        lc3b_pkg::lc3b_cacheline line;
        for (int k = 0; k < 8; k++) begin
            line[16*k +: 16] = shadow[{line_addr[15:4], 3'(k)}];
        end
        return line;
    endfunction

    task automatic fail_value(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // ==============================
    // Compare process
    // ==============================
    always @(posedge clk) begin
        logic [15:0] wb_addr;
        logic [16:0] op;
        bit          hit;
        bit          wb;
        int          idx;
        if (!arst_n_i) begin
            for (int i = 0; i < 32768; i++) begin
                shadow[i] = pattern_word(15'(i));
            end
            for (int s = 0; s < NUM_SETS; s++) begin
                m_valid[s] = 1'b0;
                m_dirty[s] = 1'b0;
            end
            exp_ops.delete();
            in_flight = 1'b0;
            checks++;
            if (mem_resp_i || pmem_read_i || pmem_write_i) begin
                errors++;
                $display("Cache output strobe active during reset at %0t", $time);
            end
        end else begin
            cycle++;
            if (pmem_resp_i) begin   // A pmem transfer ends here
                checks++;
                if (exp_ops.size() == 0) begin
                    errors++;
                    $display("Unexpected pmem transfer to line %h at %0t", pmem_address_i, $time);
                end else begin
                    op = exp_ops.pop_front();
                    if (op[16] != pmem_write_i || op[15:0] != pmem_address_i) begin
                        fail_value($sformatf("pmem write=%0b line %h, expected write=%0b line %h",
                                             pmem_write_i, pmem_address_i, op[16], op[15:0]));
                    end else if (op[16] && pmem_wdata_i != shadow_line(op[15:0])) begin
                        fail_value($sformatf("write-back data %h, expected %h",
                                             pmem_wdata_i, shadow_line(op[15:0])));
                    end
                end
            end
            if (!in_flight && (mem_read_i || mem_write_i)) begin
                exp_word = access_ref(mem_address_i, mem_write_i, mem_byte_enable_i,
                                      mem_wdata_i, hit, wb, wb_addr);
                idx = int'(mem_address_i[lc3b_pkg::OFFSET_BITS +: IDX_BITS]);
                if (wb) exp_ops.push_back({1'b1, wb_addr});   // Dirty victim first
                if (!hit) exp_ops.push_back({1'b0, mem_address_i[15:4], 4'h0});
                m_dirty[idx] = mem_write_i || (hit && m_dirty[idx]);
                m_valid[idx] = 1'b1;
                m_tag[idx]   = int'(mem_address_i >> TAG_LSB);
                req_hit      = hit;
                req_write    = mem_write_i;
                req_addr     = mem_address_i;
                accept_cycle = cycle;
                in_flight    = 1'b1;
            end
            if (mem_resp_i) begin
                checks++;
                if (!in_flight || cycle == accept_cycle) begin
                    errors++;
                    $display("Response without a pending request at %0t", $time);
                end else begin
                    if (exp_ops.size() != 0) begin
                        errors++;
                        $display("Expected pmem transfer missing for address %h", req_addr);
                        exp_ops.delete();
                    end
                    if (req_hit && cycle != accept_cycle + 1) begin
                        errors++;
                        $display("Hit on %h answered %0d cycles after the request",
                                 req_addr, cycle - accept_cycle);
                    end
                    if (req_write) begin
                        shadow[req_addr[15:1]] = exp_word;
                    end else if (mem_rdata_i != exp_word) begin
                        fail_value($sformatf("read %h returned %h, expected %h",
                                             req_addr, mem_rdata_i, exp_word));
                    end
                    in_flight = 1'b0;
                end
            end
        end
    end

endmodule : cache_checker

// ==== sim/tb_banked_cache.sv ====
module tb_banked_cache;

    localparam int NUM_BANKS      = 2;
    localparam int SETS_PER_BANK  = 4;
    localparam int SEED           = 32'hfd59;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_RANDOM     = 300;
    localparam int MAX_TXNS       = 2 * NUM_RANDOM + 64;   // Directed, random, read-back
    localparam int TIMEOUT_CYCLES = MAX_TXNS * 40 + RESET_CYCLES;
    localparam int SET_LSB        = lc3b_pkg::OFFSET_BITS + $clog2(NUM_BANKS);
    localparam int TAG_LSB        = SET_LSB + $clog2(SETS_PER_BANK);
    localparam logic [15:0] LOW_MASK = 16'((1 << TAG_LSB) - 2);

    logic                     clk;
    logic                     arst_n;
    logic                     mem_read;
    logic                     mem_write;
    lc3b_pkg::lc3b_mem_wmask  mem_byte_enable;
    lc3b_pkg::lc3b_word       mem_address;
    lc3b_pkg::lc3b_word       mem_wdata;
    logic                     mem_resp;
    lc3b_pkg::lc3b_word       mem_rdata;
    logic                     pmem_read;
    logic                     pmem_write;
    lc3b_pkg::lc3b_word       pmem_address;
    lc3b_pkg::lc3b_cacheline  pmem_wdata;
    logic                     pmem_resp;
    lc3b_pkg::lc3b_cacheline  pmem_rdata;
    int                       errors;
    int                       checks;
    int                       cycle_count = 0;
    int                       seed;
    logic [31:0]              rnd;
    logic [15:0]              addr;
    logic [15:0]              written [$];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    banked_cache #(
        .NUM_BANKS     (NUM_BANKS),
        .SETS_PER_BANK (SETS_PER_BANK)
    ) dut0 (
        .clk               (clk),
        .arst_n_i          (arst_n),
        .mem_read_i        (mem_read),
        .mem_write_i       (mem_write),
        .mem_byte_enable_i (mem_byte_enable),
        .mem_address_i     (mem_address),
        .mem_wdata_i       (mem_wdata),
        .mem_resp_o        (mem_resp),
        .mem_rdata_o       (mem_rdata),
        .pmem_read_o       (pmem_read),
        .pmem_write_o      (pmem_write),
        .pmem_address_o    (pmem_address),
        .pmem_wdata_o      (pmem_wdata),
        .pmem_resp_i       (pmem_resp),
        .pmem_rdata_i      (pmem_rdata)
    );

    tb_pmem #(
        .SEED(SEED)
    ) u_pmem (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .read_i    (pmem_read),
        .write_i   (pmem_write),
        .address_i (pmem_address),
        .wdata_i   (pmem_wdata),
        .resp_o    (pmem_resp),
        .rdata_o   (pmem_rdata)
    );

    cache_checker #(
        .NUM_BANKS     (NUM_BANKS),
        .SETS_PER_BANK (SETS_PER_BANK)
    ) u_checker (
        .clk               (clk),
        .arst_n_i          (arst_n),
        .mem_read_i        (mem_read),
        .mem_write_i       (mem_write),
        .mem_byte_enable_i (mem_byte_enable),
        .mem_address_i     (mem_address),
        .mem_wdata_i       (mem_wdata),
        .mem_resp_i        (mem_resp),
        .mem_rdata_i       (mem_rdata),
        .pmem_read_i       (pmem_read),
        .pmem_write_i      (pmem_write),
        .pmem_address_i    (pmem_address),
        .pmem_wdata_i      (pmem_wdata),
        .pmem_resp_i       (pmem_resp),
        .errors_o          (errors),
        .checks_o          (checks)
    );

    function automatic logic [15:0] make_addr(input int tag, input int set,
                                              input int bank, input int word);
        return 16'((tag << TAG_LSB) | (set << SET_LSB) | (bank << 4) | (word << 1));
    endfunction

    // One CPU access, held until the response pulse
    task automatic cpu_access(input bit is_write, input logic [15:0] a,
                              input logic [15:0] wdata, input logic [1:0] be);
        mem_address     <= a;
        mem_wdata       <= wdata;
        mem_byte_enable <= be;
        mem_read        <= !is_write;
        mem_write       <= is_write;
        @(posedge clk);
        while (!mem_resp) @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        @(posedge clk);   // Strobe low for one cycle
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        seed            = SEED;
        arst_n          <= 1'b0;
        mem_read        <= 1'b0;
        mem_write       <= 1'b0;
        mem_byte_enable <= 2'b00;
        mem_address     <= '0;
        mem_wdata       <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        cpu_access(1'b0, make_addr(0, 1, 0, 3), 16'h0, 2'b00);   // Cold miss
        cpu_access(1'b0, make_addr(0, 1, 0, 3), 16'h0, 2'b00);   // Hit
        for (int be = 0; be < 4; be++) begin
            cpu_access(1'b1, make_addr(0, 1, 0, 3), 16'(16'h1357 * (be + 3)), 2'(be));
            cpu_access(1'b0, make_addr(0, 1, 0, 3), 16'h0, 2'b00);
        end
        cpu_access(1'b0, make_addr(1, 1, 0, 3), 16'h0, 2'b00);   // Dirty victim
        cpu_access(1'b0, make_addr(2, 1, 0, 0), 16'h0, 2'b00);   // Clean victim

        // Same set in both banks
        cpu_access(1'b1, make_addr(3, 2, 0, 2), 16'hbeef, 2'b11);
        cpu_access(1'b1, make_addr(3, 2, 1, 5), 16'hcafe, 2'b11);
        for (int n = 0; n < 4; n++) begin
            cpu_access(1'b0, make_addr(3, 2, 0, 2), 16'h0, 2'b00);
            cpu_access(1'b0, make_addr(3, 2, 1, 5), 16'h0, 2'b00);
        end

        // Random traffic over four tags
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd  = $random(seed);
            addr = (16'(rnd[17:16]) << TAG_LSB) | (rnd[15:0] & LOW_MASK);
            if (rnd[20]) begin
                cpu_access(1'b1, addr, 16'($random(seed)), rnd[22:21]);
                written.push_back(addr);
            end else begin
                cpu_access(1'b0, addr, 16'h0, 2'b00);
            end
        end
        foreach (written[i]) begin
            cpu_access(1'b0, written[i], 16'h0, 2'b00);
        end

        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule : tb_banked_cache

// ==== sim/tb_pmem.sv ====
module tb_pmem #(
    parameter int SEED = 32'hfd59
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     read_i,
    input  logic                     write_i,
    input  lc3b_pkg::lc3b_word       address_i,
    input  lc3b_pkg::lc3b_cacheline  wdata_i,
    output logic                     resp_o,
    output lc3b_pkg::lc3b_cacheline  rdata_o
);

    logic [15:0] mem [32768];   // One entry per 16-bit word
    logic        busy;
    int          wait_cnt;
    int          seed = SEED;

    // Initial content, a function of the whole word address
    function automatic logic [15:0] pattern_word(input logic [14:0] widx);
        return {widx[6:0], widx[14:7], 1'b1} ^ 16'h3c5a;
    endfunction

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32768; i++) begin
                mem[i] = pattern_word(15'(i));
            end
            busy     <= 1'b0;
            wait_cnt <= 0;
            resp_o   <= 1'b0;
            rdata_o  <= '0;
        end else begin
            resp_o <= 1'b0;
            if (resp_o) begin
                // Strobe still belongs to the finished transfer
            end else if (!busy && (read_i || write_i)) begin
                busy     <= 1'b1;
                wait_cnt <= $random(seed) & 3;   // 1 to 4 cycles to resp
            end else if (busy) begin
                if (wait_cnt == 0) begin
                    busy   <= 1'b0;
                    resp_o <= 1'b1;
                    for (int k = 0; k < 8; k++) begin
                        if (write_i) begin
                            mem[{address_i[15:4], 3'(k)}] = wdata_i[16*k +: 16];
                        end else begin
                            rdata_o[16*k +: 16] <= mem[{address_i[15:4], 3'(k)}];
                        end
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule : tb_pmem
